// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // High over two rising edges, released on a falling edge
    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/udp_cmd_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "udp_cmd_cfg.svh"

module udp_cmd_tb;

    import udp_cmd_pkg::*;

    localparam int DEPTH = 1 << `FLASH_ADDR_W;

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    logic [31:0] rx_src_ip;
    logic [15:0] rx_src_port;
    logic [15:0] rx_dest_port;
    logic [15:0] rx_length;
    logic [7:0]  rx_tdata;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tready;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    logic [31:0] tx_src_ip;
    logic [31:0] tx_dest_ip;
    logic [15:0] tx_src_port;
    logic [15:0] tx_dest_port;
    logic [15:0] tx_length;
    logic [7:0]  tx_tdata;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tready;

    logic [7:0]  pay [$];
    logic [31:0] stim_lfsr = 32'h7208;
    logic [31:0] stall_lfsr = 32'h7208;
    int          stall_mode = 0;
    int          limit = 2000;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;

    // Reference model state and expected replies
    logic [7:0]  model_mem [0:DEPTH-1];
    string       exp_name [$];
    logic [31:0] exp_dest_ip [$];
    logic [15:0] exp_src_port [$];
    logic [15:0] exp_dest_port [$];
    logic [15:0] exp_length [$];
    logic [7:0]  exp_byte [$];
    logic        exp_last [$];
    string       cur_name = "none";
    logic        reply_open = 1'b0;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    udp_cmd_top udp_cmd_top_i (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip    (rx_src_ip),
        .rx_src_port  (rx_src_port),
        .rx_dest_port (rx_dest_port),
        .rx_length    (rx_length),
        .rx_tdata     (rx_tdata),
        .rx_tvalid    (rx_tvalid),
        .rx_tlast     (rx_tlast),
        .rx_tready    (rx_tready),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip    (tx_src_ip),
        .tx_dest_ip   (tx_dest_ip),
        .tx_src_port  (tx_src_port),
        .tx_dest_port (tx_dest_port),
        .tx_length    (tx_length),
        .tx_tdata     (tx_tdata),
        .tx_tvalid    (tx_tvalid),
        .tx_tlast     (tx_tlast),
        .tx_tready    (tx_tready)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_next(stim_lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] stall_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v = {v[30:0], stall_lfsr[0]};
            stall_lfsr = lfsr_next(stall_lfsr);
        end
        return v;
    endfunction

    function automatic void push_header(input string name, input logic [31:0] dest_ip,
            input logic [15:0] src_port, input logic [15:0] dest_port,
            input logic [15:0] length);
        exp_name.push_back(name);
        exp_dest_ip.push_back(dest_ip);
        exp_src_port.push_back(src_port);
        exp_dest_port.push_back(dest_port);
        exp_length.push_back(length);
    endfunction

    // Expected reply for one command, and store updates for writes
    function automatic void predict_reply(input logic [15:0] port, input logic [31:0] src_ip,
            input logic [15:0] src_port, input logic [15:0] length, input string name);
        cmd_kind_e                kind;
        logic [23:0]              full;
        logic [`FLASH_ADDR_W-1:0] addr;
        int                       i;
        case (port)
            `PORT_ECHO:     kind = CMD_ECHO;
            `PORT_FLASH_RD: kind = CMD_FLASH_RD;
            `PORT_FLASH_WR: kind = CMD_FLASH_WR;
            default:        kind = CMD_NONE;
        endcase
        if (pay.size() >= 3)
        begin
            full = {pay[2], pay[1], pay[0]};
            addr = full[`FLASH_ADDR_W-1:0];
        end
        if (kind == CMD_ECHO)
        begin
            push_header(name, src_ip, `PORT_ECHO, src_port, length);
            for (i = 0; i < pay.size(); i++)
            begin
                exp_byte.push_back(pay[i]);
                exp_last.push_back(i == pay.size() - 1);
            end
        end
        else if (kind == CMD_FLASH_RD && pay.size() >= 3)
        begin
            push_header(name, src_ip, `PORT_FLASH_RD, `PORT_FLASH_RD_REPLY,
                16'(`FLASH_RD_LEN + `UDP_HDR_LEN));
            for (i = 0; i < `FLASH_RD_LEN; i++)
            begin
                exp_byte.push_back(model_mem[addr]);
                exp_last.push_back(i == `FLASH_RD_LEN - 1);
                addr = addr + 1'b1;
            end
        end
        else if (kind == CMD_FLASH_WR && pay.size() > 6 && pay[3] == `PWD_0
                 && pay[4] == `PWD_1 && pay[5] == `PWD_2)
        begin
            for (i = 6; i < pay.size(); i++)
            begin
                model_mem[addr] = pay[i];
                addr = addr + 1'b1;
            end
        end
    endfunction

    function automatic void check_field(input string field, input logic [31:0] expv,
            input logic [31:0] actv);
        checks++;
        if (actv !== expv)
        begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", cur_name, field, expv, actv);
        end
    endfunction

    // tx_tready and tx_hdr_ready back-pressure
    always @(negedge clk)
    begin
        if (stall_mode == 0)
        begin
            tx_tready = 1'b1;
            tx_hdr_ready = 1'b1;
        end
        else if (stall_mode == 1)
        begin
            tx_tready = stall_bits(2) != 0;
            tx_hdr_ready = stall_bits(1) != 0;
        end
        else
        begin
            tx_tready = stall_bits(3) == 0;
            tx_hdr_ready = stall_bits(1) != 0;
        end
    end

    // Compare every tx header and byte against the model
    always @(posedge clk)
    begin
        if (!rst && tx_hdr_valid && tx_hdr_ready)
        begin
            if (reply_open)
            begin
                errors++;
                $display("tx header to port %h came before the previous reply ended",
                    tx_dest_port);
            end
            if (exp_name.size() == 0)
            begin
                errors++;
                $display("Unexpected tx header to port %h while no reply was due", tx_dest_port);
            end
            else
            begin
                cur_name = exp_name.pop_front();
                check_field("src_ip", `LOCAL_IP, tx_src_ip);
                check_field("dest_ip", exp_dest_ip.pop_front(), tx_dest_ip);
                check_field("src_port", exp_src_port.pop_front(), tx_src_port);
                check_field("dest_port", exp_dest_port.pop_front(), tx_dest_port);
                check_field("length", exp_length.pop_front(), tx_length);
                reply_open = 1'b1;
            end
        end
        if (!rst && tx_tvalid && tx_tready)
        begin
            if (!reply_open || exp_byte.size() == 0)
            begin
                errors++;
                $display("Unexpected tx byte %h outside a reply or with no byte due", tx_tdata);
            end
            else
            begin
                check_field("tdata", exp_byte.pop_front(), tx_tdata);
                check_field("tlast", exp_last.pop_front(), tx_tlast);
                if (tx_tlast)
                    reply_open = 1'b0;
            end
        end
    end

    // Limit grows by 40 cycles for each payload byte sent
    initial
    begin
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles with %0d reply bytes still due", cycles,
            exp_byte.size());
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic set_stall(input int mode);
        @(posedge clk);
        stall_mode = mode;
    endtask

    task automatic add_random(input int n);
        int i;
        for (i = 0; i < n; i++)
            pay.push_back(8'(stim_bits(8)));
    endtask

    // Address goes lowest byte first
    task automatic add_addr(input logic [23:0] addr);
        pay.push_back(addr[7:0]);
        pay.push_back(addr[15:8]);
        pay.push_back(addr[23:16]);
    endtask

    task automatic add_write_prefix(input logic [23:0] addr, input logic [7:0] pwd1);
        add_addr(addr);
        pay.push_back(`PWD_0);
        pay.push_back(pwd1);
        pay.push_back(`PWD_2);
    endtask

    task automatic send_cmd(input logic [15:0] port, input logic [31:0] src_ip,
            input logic [15:0] src_port, input string name);
        int i;
        predict_reply(port, src_ip, src_port, 16'(pay.size() + 8), name);
        @(negedge clk);
        rx_hdr_valid = 1'b1;
        rx_dest_port = port;
        rx_src_ip = src_ip;
        rx_src_port = src_port;
        rx_length = 16'(pay.size() + 8);
        @(posedge clk);
        while (!rx_hdr_ready)
            @(posedge clk);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (i = 0; i < pay.size(); i++)
        begin
            limit += 40;
            rx_tdata = pay[i];
            rx_tvalid = 1'b1;
            rx_tlast = i == pay.size() - 1;
            @(posedge clk);
            while (!rx_tready)
                @(posedge clk);
            @(negedge clk);
        end
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
    endtask

    task automatic read_back(input logic [23:0] addr, input string name);
        pay.delete();
        add_addr(addr);
        send_cmd(`PORT_FLASH_RD, 32'h0A00_0021, 16'd5000, name);
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_name.size() != 0 || exp_byte.size() != 0)
            @(negedge clk);
        repeat (20) @(negedge clk);
    endtask

    initial
    begin
        rx_hdr_valid = 1'b0;
        rx_src_ip = '0;
        rx_src_port = '0;
        rx_dest_port = '0;
        rx_length = '0;
        rx_tdata = '0;
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_tready = 1'b1;
        wait (!rst);
        @(posedge clk);
        checks++;
        if (!rx_hdr_ready || tx_hdr_valid || tx_tvalid)
        begin
            errors++;
            $display("After reset rx_hdr_ready is low or the tx side is not idle");
        end

        set_stall(1);
        repeat (3)
        begin
            pay.delete();
            add_random(stim_bits(5) + 1);
            send_cmd(`PORT_ECHO, 32'h0A00_0017, 16'(stim_bits(16)), "echo");
        end

        // Upper address bits are dropped, the range wraps past the top
        pay.delete();
        add_write_prefix(24'h0203FA, `PWD_1);
        add_random(16);
        send_cmd(`PORT_FLASH_WR, 32'h0A00_0021, 16'd5000, "write_wrap");
        read_back(24'h0203FA, "read_wrap");

        pay.delete();
        add_write_prefix(24'h0003FA, 8'h58);
        add_random(10);
        send_cmd(`PORT_FLASH_WR, 32'h0A00_0021, 16'd5000, "bad_password");
        read_back(24'h0003FA, "read_after_bad_password");

        wait_drained();
        pay.delete();
        add_random(12);
        send_cmd(16'h1111, 32'h0A00_0033, 16'd7000, "unknown_port");
        pay.delete();
        add_random(2);
        send_cmd(`PORT_FLASH_RD, 32'h0A00_0033, 16'd7000, "short_read");
        wait_drained();

        set_stall(2);
        read_back(24'h0003FA, "read_stalled");
        pay.delete();
        add_write_prefix(24'h000100, `PWD_1);
        add_random(16);
        send_cmd(`PORT_FLASH_WR, 32'h0A00_0021, 16'd5000, "write_during_reply");
        checks++;
        if (exp_byte.size() == 0)
        begin
            errors++;
            $display("Read reply ended before the concurrent write was consumed");
        end
        pay.delete();
        add_random(8);
        send_cmd(`PORT_ECHO, 32'h0A00_0044, 16'd6000, "echo_after_reply");
        set_stall(1);
        read_back(24'h000100, "read_concurrent_write");
        wait_drained();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/udp_cmd_pkg.sv
logic/byte_stream_if.sv
logic/flash_bus_if.sv
logic/udp_cmd_dispatch.sv
logic/flash_read_cmd.sv
logic/flash_write_cmd.sv
logic/flash_store.sv
logic/udp_cmd_top.sv
bench/tb_clock_gen.sv
bench/udp_cmd_tb.sv

// ==== logic/byte_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface byte_stream_if;
    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;

    modport src (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport snk (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );
endinterface

`default_nettype wire

// ==== logic/flash_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "udp_cmd_cfg.svh"

interface flash_bus_if;
    logic                     req;
    logic                     we;
    logic [`FLASH_ADDR_W-1:0] addr;
    logic [7:0]               wdata;
    logic                     gnt;
    logic [7:0]               rdata;
    logic                     rvalid;

    // Request taken on req and gnt, read data one cycle later
    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    modport store (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata,
        output rvalid
    );
endinterface

`default_nettype wire

// ==== logic/flash_read_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "udp_cmd_cfg.svh"

module flash_read_cmd (
    input  logic        clk,
    input  logic        rst,
    byte_stream_if.snk  cmd,
    output logic        rd_addr_ok,
    byte_stream_if.src  reply,
    flash_bus_if.client bus
);

    localparam int CNT_W = $clog2(`FLASH_RD_LEN + 1);

    logic [1:0]               addr_cnt;
    logic                     draining;
    logic                     xfer;
    logic [15:0]              addr_lo;
    logic [23:0]              full_addr;
    logic [`FLASH_ADDR_W-1:0] rd_addr;
    logic [CNT_W-1:0]         issue_left;
    logic [CNT_W-1:0]         send_left;
    logic [7:0]               skid [0:1];
    logic [1:0]               fill;
    logic [2:0]               level;
    logic                     wr_slot;
    logic                     push;
    logic                     pop;

    // Address bytes arrive lowest first, anything after them is dropped
    assign cmd.tready = 1'b1;
    assign xfer = cmd.tvalid && cmd.tready;
    assign full_addr = {cmd.tdata, addr_lo};
    assign rd_addr_ok = xfer && !draining && addr_cnt == 2'd2;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            addr_cnt <= 2'd0;
            draining <= 1'b0;
        end
        else if (xfer)
        begin
            if (cmd.tlast)
            begin
                addr_cnt <= 2'd0;
                draining <= 1'b0;
            end
            else if (rd_addr_ok)
            begin
                addr_cnt <= 2'd0;
                draining <= 1'b1;
            end
            else if (!draining)
            begin
                addr_cnt <= addr_cnt + 2'd1;
            end
        end
    end

    assign push = bus.rvalid;
    assign pop = reply.tvalid && reply.tready;
    assign level = 3'(fill) + 3'(push) - 3'(pop);
    assign wr_slot = pop ? (fill == 2'd2) : fill[0];

    // Leave room for the read that lands next cycle
    assign bus.req = issue_left != '0 && level < 3'd2;
    assign bus.we = 1'b0;
    assign bus.addr = rd_addr;
    assign bus.wdata = 8'h00;

    assign reply.tdata = skid[0];
    assign reply.tvalid = fill != 2'd0;
    assign reply.tlast = reply.tvalid && send_left == CNT_W'(1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fill <= 2'd0;
            issue_left <= '0;
            send_left <= '0;
        end
        else
        begin
            fill <= level[1:0];
            if (rd_addr_ok)
            begin
                issue_left <= CNT_W'(`FLASH_RD_LEN);
                send_left <= CNT_W'(`FLASH_RD_LEN);
            end
            else
            begin
                if (bus.req && bus.gnt)
                    issue_left <= issue_left - 1'b1;
                if (pop)
                    send_left <= send_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (addr_cnt != 2'd2 && xfer && !draining)
            addr_lo <= full_addr[23:8];
        // Wraps at the top of the store
        if (rd_addr_ok)
            rd_addr <= full_addr[`FLASH_ADDR_W-1:0];
        else if (bus.req && bus.gnt)
            rd_addr <= rd_addr + 1'b1;
        if (pop)
            skid[0] <= skid[1];
        if (push)
            skid[wr_slot] <= bus.rdata;
    end

    reads_in_flight: assert property (@(posedge clk) disable iff (rst)
        3'(fill) + 3'(bus.rvalid) <= 3'd2);

endmodule

`default_nettype wire

// ==== logic/flash_store.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "udp_cmd_cfg.svh"

module flash_store (
    input  logic       clk,
    input  logic       rst,
    flash_bus_if.store rd_bus,
    flash_bus_if.store wr_bus
);

    localparam int DEPTH = 1 << `FLASH_ADDR_W;

    logic [7:0]               mem [0:DEPTH-1];
    logic [7:0]               rdata_q;
    logic                     last_wr;
    logic                     rd_win;
    logic                     wr_win;
    logic [`FLASH_ADDR_W-1:0] sel_addr;
    logic                     sel_we;
    logic [7:0]               sel_wdata;
    logic                     rd_rvalid_q;
    logic                     wr_rvalid_q;

    // On a tie the client not served last goes first
    assign rd_win = rd_bus.req && (!wr_bus.req || last_wr);
    assign wr_win = wr_bus.req && !rd_win;

    assign rd_bus.gnt = rd_win;
    assign wr_bus.gnt = wr_win;

    assign sel_addr = rd_win ? rd_bus.addr : wr_bus.addr;
    assign sel_we = rd_win ? rd_bus.we : (wr_win && wr_bus.we);
    assign sel_wdata = rd_win ? rd_bus.wdata : wr_bus.wdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_wr <= 1'b0;
            rd_rvalid_q <= 1'b0;
            wr_rvalid_q <= 1'b0;
        end
        else
        begin
            if (rd_win)
                last_wr <= 1'b0;
            else if (wr_win)
                last_wr <= 1'b1;
            rd_rvalid_q <= rd_win && !rd_bus.we;
            wr_rvalid_q <= wr_win && !wr_bus.we;
        end
    end

    // Byte array, registered read
    always_ff @(posedge clk)
    begin
        if (sel_we)
            mem[sel_addr] <= sel_wdata;
        rdata_q <= mem[sel_addr];
    end

    assign rd_bus.rdata = rdata_q;
    assign wr_bus.rdata = rdata_q;
    assign rd_bus.rvalid = rd_rvalid_q;
    assign wr_bus.rvalid = wr_rvalid_q;

    one_grant: assert property (@(posedge clk) disable iff (rst)
        !(rd_bus.gnt && wr_bus.gnt));

endmodule

`default_nettype wire

// ==== logic/flash_write_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "udp_cmd_cfg.svh"

module flash_write_cmd (
    input  logic        clk,
    input  logic        rst,
    byte_stream_if.snk  cmd,
    flash_bus_if.client bus
);

    localparam int PREFIX_LEN = 6;

    logic [2:0]               prefix_cnt;
    logic                     bad_pwd;
    logic                     in_prefix;
    logic                     writing;
    logic                     pwd_miss;
    logic                     xfer;
    logic [15:0]              addr_lo;
    logic [23:0]              full_addr;
    logic [`FLASH_ADDR_W-1:0] wr_addr;

    assign in_prefix = prefix_cnt < 3'(PREFIX_LEN);
    assign writing = !in_prefix && !bad_pwd;
    assign xfer = cmd.tvalid && cmd.tready;
    assign full_addr = {cmd.tdata, addr_lo};

    // Data byte stays on the stream until the store grants its write
    assign bus.req = writing && cmd.tvalid;
    assign bus.we = 1'b1;
    assign bus.addr = wr_addr;
    assign bus.wdata = cmd.tdata;
    assign cmd.tready = writing ? bus.gnt : 1'b1;

    always_comb
    begin
        case (prefix_cnt)
            3'd3:    pwd_miss = cmd.tdata != `PWD_0;
            3'd4:    pwd_miss = cmd.tdata != `PWD_1;
            3'd5:    pwd_miss = cmd.tdata != `PWD_2;
            default: pwd_miss = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prefix_cnt <= 3'd0;
            bad_pwd <= 1'b0;
        end
        else if (xfer)
        begin
            if (cmd.tlast)
            begin
                prefix_cnt <= 3'd0;
                bad_pwd <= 1'b0;
            end
            else if (in_prefix)
            begin
                prefix_cnt <= prefix_cnt + 3'd1;
                // Rest of the payload is drained
                if (pwd_miss)
                    bad_pwd <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer && prefix_cnt < 3'd2)
            addr_lo <= full_addr[23:8];
        if (xfer && prefix_cnt == 3'd2)
            wr_addr <= full_addr[`FLASH_ADDR_W-1:0];
        else if (xfer && writing)
            wr_addr <= wr_addr + 1'b1;
    end

endmodule

`default_nettype wire

// ==== logic/udp_cmd_cfg.svh ====
`ifndef UDP_CMD_CFG_SVH
`define UDP_CMD_CFG_SVH

// UDP ports served
`define PORT_ECHO           16'd1234
`define PORT_FLASH_RD       16'hEEE0
`define PORT_FLASH_RD_REPLY 16'hEEE1
`define PORT_FLASH_WR       16'hEEE2

// Byte store geometry and read reply size
`define FLASH_ADDR_W 10
`define FLASH_RD_LEN 16
`define UDP_HDR_LEN  8

// Write password 'E' 'P' 'W'
`define PWD_0 8'h45
`define PWD_1 8'h50
`define PWD_2 8'h57

`define LOCAL_IP 32'hC0A8_0280

`endif

// ==== logic/udp_cmd_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "udp_cmd_cfg.svh"

module udp_cmd_dispatch (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  logic [31:0] rx_src_ip,
    input  logic [15:0] rx_src_port,
    input  logic [15:0] rx_dest_port,
    input  logic [15:0] rx_length,
    input  logic [7:0]  rx_tdata,
    input  logic        rx_tvalid,
    input  logic        rx_tlast,
    output logic        rx_tready,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output logic [31:0] tx_src_ip,
    output logic [31:0] tx_dest_ip,
    output logic [15:0] tx_src_port,
    output logic [15:0] tx_dest_port,
    output logic [15:0] tx_length,
    output logic [7:0]  tx_tdata,
    output logic        tx_tvalid,
    output logic        tx_tlast,
    input  logic        tx_tready,
    byte_stream_if.src  rd_cmd,
    byte_stream_if.src  wr_cmd,
    byte_stream_if.snk  rd_reply,
    input  logic        rd_addr_ok
);

    import udp_cmd_pkg::*;

    cmd_kind_e in_kind;
    cmd_kind_e cur_kind;
    logic      rx_busy;
    logic      reply_active;
    logic      held;
    logic      hdr_xfer;
    logic      rx_last_xfer;
    logic      reply_last_xfer;
    logic      echo_flow;
    logic      reply_flow;

    always_comb
    begin
        case (rx_dest_port)
            `PORT_ECHO:     in_kind = CMD_ECHO;
            `PORT_FLASH_RD: in_kind = CMD_FLASH_RD;
            `PORT_FLASH_WR: in_kind = CMD_FLASH_WR;
            default:        in_kind = CMD_NONE;
        endcase
    end

    // Echo and read both need tx, which a running reply owns
    assign held = reply_active && (in_kind == CMD_ECHO || in_kind == CMD_FLASH_RD);
    assign rx_hdr_ready = !rx_busy && !held;
    assign hdr_xfer = rx_hdr_valid && rx_hdr_ready;

    // Payload moves only once its tx header is gone
    assign echo_flow = rx_busy && cur_kind == CMD_ECHO && !tx_hdr_valid;
    assign reply_flow = reply_active && !tx_hdr_valid;

    assign rd_cmd.tdata = rx_tdata;
    assign rd_cmd.tlast = rx_tlast;
    assign rd_cmd.tvalid = rx_busy && cur_kind == CMD_FLASH_RD && rx_tvalid;
    assign wr_cmd.tdata = rx_tdata;
    assign wr_cmd.tlast = rx_tlast;
    assign wr_cmd.tvalid = rx_busy && cur_kind == CMD_FLASH_WR && rx_tvalid;

    always_comb
    begin
        rx_tready = 1'b0;
        if (rx_busy)
        begin
            case (cur_kind)
                CMD_ECHO:     rx_tready = echo_flow && tx_tready;
                CMD_FLASH_RD: rx_tready = rd_cmd.tready;
                CMD_FLASH_WR: rx_tready = wr_cmd.tready;
                default:      rx_tready = 1'b1;
            endcase
        end
    end

    assign rx_last_xfer = rx_tvalid && rx_tready && rx_tlast;
    assign reply_last_xfer = rd_reply.tvalid && rd_reply.tready && rd_reply.tlast;

    assign tx_src_ip = `LOCAL_IP;
    assign tx_tdata = reply_flow ? rd_reply.tdata : rx_tdata;
    assign tx_tvalid = reply_flow ? rd_reply.tvalid : (echo_flow && rx_tvalid);
    assign tx_tlast = reply_flow ? rd_reply.tlast : (echo_flow && rx_tvalid && rx_tlast);
    assign rd_reply.tready = reply_flow && tx_tready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_busy <= 1'b0;
            cur_kind <= CMD_NONE;
            reply_active <= 1'b0;
            tx_hdr_valid <= 1'b0;
        end
        else
        begin
            if (hdr_xfer)
            begin
                rx_busy <= 1'b1;
                cur_kind <= in_kind;
            end
            else if (rx_last_xfer)
            begin
                rx_busy <= 1'b0;
            end

            if (rd_addr_ok)
                reply_active <= 1'b1;
            else if (reply_last_xfer)
                reply_active <= 1'b0;

            if (tx_hdr_valid && tx_hdr_ready)
                tx_hdr_valid <= 1'b0;
            else if ((hdr_xfer && in_kind == CMD_ECHO) || rd_addr_ok)
                tx_hdr_valid <= 1'b1;
        end
    end

    // Reply addressing, latched when the command is taken
    always_ff @(posedge clk)
    begin
        if (hdr_xfer && in_kind == CMD_ECHO)
        begin
            tx_dest_ip <= rx_src_ip;
            tx_src_port <= `PORT_ECHO;
            tx_dest_port <= rx_src_port;
            tx_length <= rx_length;
        end
        else if (hdr_xfer && in_kind == CMD_FLASH_RD)
        begin
            tx_dest_ip <= rx_src_ip;
            tx_src_port <= `PORT_FLASH_RD;
            tx_dest_port <= `PORT_FLASH_RD_REPLY;
            tx_length <= 16'(`FLASH_RD_LEN + `UDP_HDR_LEN);
        end
    end

    tx_last_has_valid: assert property (@(posedge clk) disable iff (rst)
        tx_tlast |-> tx_tvalid);

endmodule

`default_nettype wire

// ==== logic/udp_cmd_pkg.sv ====
`default_nettype none

package udp_cmd_pkg;

    // What the current rx payload belongs to
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_ECHO,
        CMD_FLASH_RD,
        CMD_FLASH_WR
    } cmd_kind_e;

endpackage

`default_nettype wire

// ==== logic/udp_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_cmd_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  logic [31:0] rx_src_ip,
    input  logic [15:0] rx_src_port,
    input  logic [15:0] rx_dest_port,
    input  logic [15:0] rx_length,
    input  logic [7:0]  rx_tdata,
    input  logic        rx_tvalid,
    input  logic        rx_tlast,
    output logic        rx_tready,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output logic [31:0] tx_src_ip,
    output logic [31:0] tx_dest_ip,
    output logic [15:0] tx_src_port,
    output logic [15:0] tx_dest_port,
    output logic [15:0] tx_length,
    output logic [7:0]  tx_tdata,
    output logic        tx_tvalid,
    output logic        tx_tlast,
    input  logic        tx_tready
);

    logic rd_addr_ok;

    byte_stream_if rd_cmd ();
    byte_stream_if wr_cmd ();
    byte_stream_if rd_reply ();
    flash_bus_if   rd_bus ();
    flash_bus_if   wr_bus ();

    udp_cmd_dispatch udp_cmd_dispatch_i (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip    (rx_src_ip),
        .rx_src_port  (rx_src_port),
        .rx_dest_port (rx_dest_port),
        .rx_length    (rx_length),
        .rx_tdata     (rx_tdata),
        .rx_tvalid    (rx_tvalid),
        .rx_tlast     (rx_tlast),
        .rx_tready    (rx_tready),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip    (tx_src_ip),
        .tx_dest_ip   (tx_dest_ip),
        .tx_src_port  (tx_src_port),
        .tx_dest_port (tx_dest_port),
        .tx_length    (tx_length),
        .tx_tdata     (tx_tdata),
        .tx_tvalid    (tx_tvalid),
        .tx_tlast     (tx_tlast),
        .tx_tready    (tx_tready),
        .rd_cmd       (rd_cmd.src),
        .wr_cmd       (wr_cmd.src),
        .rd_reply     (rd_reply.snk),
        .rd_addr_ok   (rd_addr_ok)
    );

    flash_read_cmd flash_read_cmd_i (
        .clk        (clk),
        .rst        (rst),
        .cmd        (rd_cmd.snk),
        .rd_addr_ok (rd_addr_ok),
        .reply      (rd_reply.src),
        .bus        (rd_bus.client)
    );

    flash_write_cmd flash_write_cmd_i (
        .clk (clk),
        .rst (rst),
        .cmd (wr_cmd.snk),
        .bus (wr_bus.client)
    );

    flash_store flash_store_i (
        .clk    (clk),
        .rst    (rst),
        .rd_bus (rd_bus.store),
        .wr_bus (wr_bus.store)
    );

endmodule

`default_nettype wire
